//--- design/compositor_pkg.sv
//************************************************
// Shared types for the compositor
// State literals carry a BLEND_ or SCAN_ prefix so both enums
// can share the package without name clashes
//************************************************

package compositor_pkg;

	// One frame-buffer entry, 8 bits per channel
	typedef struct packed
	{
		logic [7:0] r;
		logic [7:0] g;
		logic [7:0] b;
	} pixel_t;

	// Blender read-modify-write sequence
	typedef enum logic [1:0]
	{
		BLEND_IDLE      = 2'd0,
		BLEND_READ_REQ  = 2'd1,
		BLEND_READ_WAIT = 2'd2,
		BLEND_WRITE_REQ = 2'd3
	} blend_state_t;

	// Scanout walk over the frame
	typedef enum logic [1:0]
	{
		SCAN_IDLE      = 2'd0,
		SCAN_READ_REQ  = 2'd1,
		SCAN_READ_WAIT = 2'd2,
		SCAN_DONE      = 2'd3
	} scan_state_t;

	// Frame-buffer bus command
	typedef enum logic
	{
		OP_READ  = 1'b0,
		OP_WRITE = 1'b1
	} bus_op_t;

endpackage

//--- design/fb_bus_if.sv
//************************************************
// One frame-buffer bus link, request/grant handshake
// Master holds req, op, addr, wdata until gnt is seen
// rvalid comes one cycle after a read grant
//************************************************

`timescale 1ns/1ps

interface fb_bus_if
#(
	parameter int ADDR_W = 4
)
();
	import compositor_pkg::*;

	// Master side
	logic              req;
	bus_op_t           op;
	logic [ADDR_W-1:0] addr;
	pixel_t            wdata;

	// Arbiter or memory side
	logic              gnt;
	logic              rvalid;
	pixel_t            rdata;

	modport master
	(
		output req, op, addr, wdata,
		input  gnt, rvalid, rdata
	);

	// Arbiter faces a master from the slave side
	modport arbiter
	(
		input  req, op, addr, wdata,
		output gnt, rvalid, rdata
	);

	modport memory
	(
		input  req, op, addr, wdata,
		output gnt, rvalid, rdata
	);

endinterface

//--- design/alpha_blender.sv
//************************************************
// Read-blend-write engine, one pixel per strobe
// Strobe is taken only while idle, host watches blend_busy
// Destination must have been written before it is blended
//************************************************

`timescale 1ns/1ps

module alpha_blender
#(
	parameter int ADDR_W = 4
)
(
	input  logic              clk,
	input  logic              reset,
	input  logic              pixel_strobe,
	input  logic [ADDR_W-1:0] pixel_number,
	input  logic [7:0]        src_r,
	input  logic [7:0]        src_g,
	input  logic [7:0]        src_b,
	input  logic [7:0]        src_a,
	fb_bus_if.master          bus,
	output logic              blend_done,
	output logic              blend_busy,
	output logic [ADDR_W-1:0] blend_pixel,
	output logic [7:0]        blend_r,
	output logic [7:0]        blend_g,
	output logic [7:0]        blend_b
);
	import compositor_pkg::*;

	blend_state_t      state;
	pixel_t            src_q;
	logic [7:0]        alpha_q;
	logic [ADDR_W-1:0] pix_q;
	pixel_t            dst_q;
	pixel_t            mix;

	// One channel of the blend rule
	function automatic logic [7:0] blend_ch
	(
		input logic [7:0] s,
		input logic [7:0] d,
		input logic [7:0] a
	);
		logic [15:0] sum;
		if (a == 8'd0)
			blend_ch = d;
		else if (a == 8'd255)
			blend_ch = s;
		else
		begin
			// Max 255*255 fits in 16 bits
			sum = (16'(s) * 16'(a)) + (16'(d) * 16'(8'd255 - a));
			blend_ch = sum[15:8];
		end
	endfunction

	// Mix from the registered destination pixel
	always_comb
	begin
		mix.r = blend_ch(src_q.r, dst_q.r, alpha_q);
		mix.g = blend_ch(src_q.g, dst_q.g, alpha_q);
		mix.b = blend_ch(src_q.b, dst_q.b, alpha_q);
	end

	// Bus requests follow the state directly
	assign bus.req   = (state == BLEND_READ_REQ) || (state == BLEND_WRITE_REQ);
	assign bus.op    = (state == BLEND_WRITE_REQ) ? OP_WRITE : OP_READ;
	assign bus.addr  = pix_q;
	assign bus.wdata = mix;

	// Pixel number stays valid through blend_done
	assign blend_pixel = pix_q;

	// Control FSM
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state      <= BLEND_IDLE;
			blend_busy <= 1'b0;
			blend_done <= 1'b0;
		end
		else
		begin
			// Done is a single-cycle pulse
			blend_done <= 1'b0;
			case (state)
				BLEND_IDLE:
					if (pixel_strobe)
					begin
						state      <= BLEND_READ_REQ;
						blend_busy <= 1'b1;
					end
				BLEND_READ_REQ:
					if (bus.gnt)
						state <= BLEND_READ_WAIT;
				BLEND_READ_WAIT:
					if (bus.rvalid)
						state <= BLEND_WRITE_REQ;
				BLEND_WRITE_REQ:
					if (bus.gnt)
					begin
						// Write lands this cycle
						state      <= BLEND_IDLE;
						blend_busy <= 1'b0;
						blend_done <= 1'b1;
					end
				default:
					state <= BLEND_IDLE;
			endcase
		end
	end

	// Source latch, destination capture, result
	always_ff @(posedge clk)
	begin
		if ((state == BLEND_IDLE) && pixel_strobe)
		begin
			src_q   <= '{r: src_r, g: src_g, b: src_b};
			alpha_q <= src_a;
			pix_q   <= pixel_number;
		end
		if ((state == BLEND_READ_WAIT) && bus.rvalid)
			dst_q <= bus.rdata;
		if ((state == BLEND_WRITE_REQ) && bus.gnt)
		begin
			blend_r <= mix.r;
			blend_g <= mix.g;
			blend_b <= mix.b;
		end
	end

endmodule

//--- design/scanout_reader.sv
//************************************************
// Streams the frame out in pixel order, one read at a time
// frame_start is ignored while a scan is running
//************************************************

`timescale 1ns/1ps

module scanout_reader
#(
	parameter int ADDR_W = 4,
	parameter int PIXELS = 16
)
(
	input  logic              clk,
	input  logic              reset,
	input  logic              frame_start,
	fb_bus_if.master          bus,
	output logic              scan_valid,
	output logic [ADDR_W-1:0] scan_pixel,
	output logic [7:0]        scan_r,
	output logic [7:0]        scan_g,
	output logic [7:0]        scan_b,
	output logic              frame_done
);
	import compositor_pkg::*;

	scan_state_t       state;
	logic [ADDR_W-1:0] count;
	logic              last;

	assign last = (count == ADDR_W'(PIXELS - 1));

	// Read-only master
	assign bus.req   = (state == SCAN_READ_REQ);
	assign bus.op    = OP_READ;
	assign bus.addr  = count;
	assign bus.wdata = '0;

	// Returned data goes straight out, one cycle after the grant
	assign scan_valid = (state == SCAN_READ_WAIT) && bus.rvalid;
	assign scan_pixel = count;
	assign scan_r     = bus.rdata.r;
	assign scan_g     = bus.rdata.g;
	assign scan_b     = bus.rdata.b;
	assign frame_done = scan_valid && last;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= SCAN_IDLE;
			count <= '0;
		end
		else
		begin
			case (state)
				SCAN_IDLE:
					if (frame_start)
					begin
						state <= SCAN_READ_REQ;
						count <= '0;
					end
				SCAN_READ_REQ:
					if (bus.gnt)
						state <= SCAN_READ_WAIT;
				SCAN_READ_WAIT:
					if (bus.rvalid)
					begin
						if (last)
							state <= SCAN_DONE;
						else
						begin
							// Next pixel
							count <= count + 1'b1;
							state <= SCAN_READ_REQ;
						end
					end
				// One quiet cycle before a new frame_start is accepted
				SCAN_DONE:
					state <= SCAN_IDLE;
				default:
					state <= SCAN_IDLE;
			endcase
		end
	end

endmodule

//--- design/fb_arbiter.sv
//************************************************
// Round-robin join of two masters onto one memory link
// Grant is same-cycle, memory must answer gnt = req
//************************************************

`timescale 1ns/1ps

module fb_arbiter
(
	input  logic      clk,
	input  logic      reset,
	fb_bus_if.arbiter m0,
	fb_bus_if.arbiter m1,
	fb_bus_if.master  mem
);
	import compositor_pkg::*;

	logic last_winner;
	logic owner;
	logic pick1;

	// m1 wins alone, or on a tie when m0 won last
	assign pick1 = m1.req && (!m0.req || (last_winner == 1'b0));

	// Winner onto the memory link
	assign mem.req   = m0.req || m1.req;
	assign mem.op    = pick1 ? m1.op    : m0.op;
	assign mem.addr  = pick1 ? m1.addr  : m0.addr;
	assign mem.wdata = pick1 ? m1.wdata : m0.wdata;

	assign m0.gnt = mem.gnt && !pick1;
	assign m1.gnt = mem.gnt && pick1;

	// Read return only to the master that issued it
	assign m0.rvalid = mem.rvalid && (owner == 1'b0);
	assign m1.rvalid = mem.rvalid && (owner == 1'b1);
	assign m0.rdata  = (owner == 1'b0) ? mem.rdata : '0;
	assign m1.rdata  = (owner == 1'b1) ? mem.rdata : '0;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			// m0 gets the first tie
			last_winner <= 1'b1;
			owner       <= 1'b0;
		end
		else if (mem.gnt)
		begin
			last_winner <= pick1;
			// Read data returns next cycle, remember whose it is
			if (mem.op == OP_READ)
				owner <= pick1;
		end
	end

endmodule

//--- design/frame_buffer.sv
//************************************************
// Single-port pixel RAM, read latency of one cycle
// Contents are undefined until written, no clear at reset
//************************************************

`timescale 1ns/1ps

module frame_buffer
#(
	parameter int PIXELS = 16
)
(
	input  logic     clk,
	fb_bus_if.memory bus
);
	import compositor_pkg::*;

	pixel_t mem [PIXELS];

	// Every request is taken at once
	assign bus.gnt = bus.req;

	always_ff @(posedge clk)
	begin
		// Write in the command cycle
		if (bus.req && (bus.op == OP_WRITE))
			mem[bus.addr] <= bus.wdata;
		// Registered read data with its strobe
		bus.rdata  <= mem[bus.addr];
		bus.rvalid <= bus.req && (bus.op == OP_READ);
	end

endmodule

//--- design/compositor_top.sv
//************************************************
// Alpha-blending compositor top, plain ports only
// Host must not strobe a pixel while blend_busy is high
// No back-pressure on the scan stream
//************************************************

`timescale 1ns/1ps

module compositor_top
#(
	parameter int ADDR_W = 4,
	parameter int PIXELS = 16
)
(
	input  logic              clk,
	input  logic              reset,
	input  logic              pixel_strobe,
	input  logic [ADDR_W-1:0] pixel_number,
	input  logic [7:0]        src_r,
	input  logic [7:0]        src_g,
	input  logic [7:0]        src_b,
	input  logic [7:0]        src_a,
	input  logic              frame_start,
	output logic              blend_done,
	output logic              blend_busy,
	output logic [ADDR_W-1:0] blend_pixel,
	output logic [7:0]        blend_r,
	output logic [7:0]        blend_g,
	output logic [7:0]        blend_b,
	output logic              scan_valid,
	output logic [ADDR_W-1:0] scan_pixel,
	output logic [7:0]        scan_r,
	output logic [7:0]        scan_g,
	output logic [7:0]        scan_b,
	output logic              frame_done
);

	// Blender link, scanout link, shared memory link
	fb_bus_if #(.ADDR_W(ADDR_W)) blend_bus ();
	fb_bus_if #(.ADDR_W(ADDR_W)) scan_bus ();
	fb_bus_if #(.ADDR_W(ADDR_W)) mem_bus ();

	alpha_blender #(.ADDR_W(ADDR_W)) blender0
	(
		.clk          (clk),
		.reset        (reset),
		.pixel_strobe (pixel_strobe),
		.pixel_number (pixel_number),
		.src_r        (src_r),
		.src_g        (src_g),
		.src_b        (src_b),
		.src_a        (src_a),
		.bus          (blend_bus.master),
		.blend_done   (blend_done),
		.blend_busy   (blend_busy),
		.blend_pixel  (blend_pixel),
		.blend_r      (blend_r),
		.blend_g      (blend_g),
		.blend_b      (blend_b)
	);

	scanout_reader #(.ADDR_W(ADDR_W), .PIXELS(PIXELS)) scan0
	(
		.clk         (clk),
		.reset       (reset),
		.frame_start (frame_start),
		.bus         (scan_bus.master),
		.scan_valid  (scan_valid),
		.scan_pixel  (scan_pixel),
		.scan_r      (scan_r),
		.scan_g      (scan_g),
		.scan_b      (scan_b),
		.frame_done  (frame_done)
	);

	// Blender on m0, gets the first tie after reset
	fb_arbiter arb0
	(
		.clk   (clk),
		.reset (reset),
		.m0    (blend_bus.arbiter),
		.m1    (scan_bus.arbiter),
		.mem   (mem_bus.master)
	);

	frame_buffer #(.PIXELS(PIXELS)) fb0
	(
		.clk (clk),
		.bus (mem_bus.memory)
	);

endmodule

//--- verification/compositor_checker.sv
//************************************************
// Watches the compositor ports and keeps a model frame
// Scan values are skipped for pixels blended during that scan
// Latency is checked only for blends with no scan running
//************************************************

`timescale 1ns/1ps

module compositor_checker
#(
	parameter int ADDR_W = 4,
	parameter int PIXELS = 16
)
(
	input  logic              clk,
	input  logic              reset,
	input  logic              pixel_strobe,
	input  logic [ADDR_W-1:0] pixel_number,
	input  logic [7:0]        src_r,
	input  logic [7:0]        src_g,
	input  logic [7:0]        src_b,
	input  logic [7:0]        src_a,
	input  logic              frame_start,
	input  logic              blend_done,
	input  logic              blend_busy,
	input  logic [ADDR_W-1:0] blend_pixel,
	input  logic [7:0]        blend_r,
	input  logic [7:0]        blend_g,
	input  logic [7:0]        blend_b,
	input  logic              scan_valid,
	input  logic [ADDR_W-1:0] scan_pixel,
	input  logic [7:0]        scan_r,
	input  logic [7:0]        scan_g,
	input  logic [7:0]        scan_b,
	input  logic              frame_done,
	input  logic              table_check,
	input  logic [7:0]        table_r,
	input  logic [7:0]        table_g,
	input  logic [7:0]        table_b,
	output int                error_count,
	output int                blend_count,
	output int                pixel_count
);

	// Model frame with one byte array per channel
	logic [7:0]        model_r [PIXELS];
	logic [7:0]        model_g [PIXELS];
	logic [7:0]        model_b [PIXELS];
	logic              touched [PIXELS];

	// Blend in flight
	logic              pend;
	logic              contended;
	int                pend_cycles;
	logic [ADDR_W-1:0] pend_pix;
	logic [7:0]        pend_r;
	logic [7:0]        pend_g;
	logic [7:0]        pend_b;
	logic [7:0]        pend_a;
	logic              pend_table;
	logic [7:0]        pend_tr;
	logic [7:0]        pend_tg;
	logic [7:0]        pend_tb;
	logic [7:0]        exp_r;
	logic [7:0]        exp_g;
	logic [7:0]        exp_b;

	// Scan in progress and next pixel expected
	logic              scan_on;
	int                scan_next;

	// One channel by the blend rule
	function automatic logic [7:0] mix_channel
	(
		input logic [7:0] s,
		input logic [7:0] d,
		input logic [7:0] a
	);
		int sum;
		if (a == 8'd0)
			return d;
		if (a == 8'd255)
			return s;
		sum = int'(s) * int'(a) + int'(d) * (255 - int'(a));
		return 8'(sum >> 8);
	endfunction

	task automatic report_mismatch(input string msg);
		error_count++;
		$display("FAILED at %0d ns: %s", $time, msg);
	endtask

	initial
	begin
		error_count = 0;
		blend_count = 0;
		pixel_count = 0;
		pend        = 1'b0;
		scan_on     = 1'b0;
		scan_next   = 0;
	end

	always @(posedge clk)
	begin
		if (reset)
		begin
			pend    = 1'b0;
			scan_on = 1'b0;
		end
		else
		begin
			// A new scan starts only from idle
			if (frame_start && !scan_on)
			begin
				scan_on   = 1'b1;
				scan_next = 0;
				for (int i = 0; i < PIXELS; i++)
					touched[i] = 1'b0;
			end
			if (pend)
			begin
				pend_cycles++;
				// Write has already landed by the done cycle
				if (scan_on && !blend_done)
				begin
					contended         = 1'b1;
					touched[pend_pix] = 1'b1;
				end
				// Busy stays high up to the done cycle and falls with it
				if (blend_busy == blend_done)
					report_mismatch($sformatf("blend_busy %0b with blend_done %0b",
						blend_busy, blend_done));
			end

			// Scan stream
			if (scan_valid)
			begin
				if (!scan_on)
					report_mismatch("scan_valid while no scan is running");
				else
				begin
					if (int'(scan_pixel) != scan_next)
						report_mismatch($sformatf("scan pixel %0d, expected %0d",
							scan_pixel, scan_next));
					else if (!touched[scan_pixel] &&
						{scan_r, scan_g, scan_b} !==
						{model_r[scan_pixel], model_g[scan_pixel], model_b[scan_pixel]})
						report_mismatch($sformatf("scan pixel %0d is %h %h %h, expected %h %h %h",
							scan_pixel, scan_r, scan_g, scan_b, model_r[scan_pixel],
							model_g[scan_pixel], model_b[scan_pixel]));
					if (frame_done != (scan_next == PIXELS - 1))
						report_mismatch($sformatf("frame_done %0b at scan pixel %0d",
							frame_done, scan_next));
					pixel_count++;
					scan_next++;
					if (frame_done)
						scan_on = 1'b0;
				end
			end
			else if (frame_done)
				report_mismatch("frame_done without scan_valid");

			// Blend result
			if (blend_done)
			begin
				if (!pend)
					report_mismatch("blend_done with no blend pending");
				else
				begin
					exp_r = mix_channel(pend_r, model_r[pend_pix], pend_a);
					exp_g = mix_channel(pend_g, model_g[pend_pix], pend_a);
					exp_b = mix_channel(pend_b, model_b[pend_pix], pend_a);
					if (blend_pixel !== pend_pix)
						report_mismatch($sformatf("blend_pixel %0d, expected %0d",
							blend_pixel, pend_pix));
					if ({blend_r, blend_g, blend_b} !== {exp_r, exp_g, exp_b})
						report_mismatch($sformatf("blend pixel %0d is %h %h %h, model %h %h %h",
							pend_pix, blend_r, blend_g, blend_b, exp_r, exp_g, exp_b));
					if (pend_table && {blend_r, blend_g, blend_b} !== {pend_tr, pend_tg, pend_tb})
						report_mismatch($sformatf("blend pixel %0d is %h %h %h, table %h %h %h",
							pend_pix, blend_r, blend_g, blend_b, pend_tr, pend_tg, pend_tb));
					if (!contended && pend_cycles != 4)
						report_mismatch($sformatf("blend_done after %0d cycles, expected 4",
							pend_cycles));
					model_r[pend_pix] = exp_r;
					model_g[pend_pix] = exp_g;
					model_b[pend_pix] = exp_b;
					pend = 1'b0;
					blend_count++;
				end
			end

			// Strobe is taken last so a done in the same cycle frees the slot
			if (pixel_strobe)
			begin
				if (pend)
					report_mismatch("pixel_strobe while a blend is pending");
				else
				begin
					pend        = 1'b1;
					contended   = scan_on;
					pend_cycles = 0;
					pend_pix    = pixel_number;
					pend_r      = src_r;
					pend_g      = src_g;
					pend_b      = src_b;
					pend_a      = src_a;
					pend_table  = table_check;
					pend_tr     = table_r;
					pend_tg     = table_g;
					pend_tb     = table_b;
				end
			end
		end
	end

endmodule

//--- verification/tb_compositor.sv
//************************************************
// Compositor testbench with a 100 ns clock
// Inputs change on the falling edge
// Every pixel is written with alpha 255 before it is blended
//************************************************

`timescale 1ns/1ps

module tb_compositor;

	localparam int ADDR_W  = 4;
	localparam int PIXELS  = 16;
	localparam int TIMEOUT = 200;

	typedef enum logic [1:0]
	{
		ROW_BLEND,
		ROW_SCAN,
		ROW_SCAN_START,
		ROW_SCAN_WAIT
	} row_kind_t;

	// One stimulus row with the table result where it is known
	typedef struct packed
	{
		row_kind_t         kind;
		logic [ADDR_W-1:0] pix;
		logic [7:0]        r;
		logic [7:0]        g;
		logic [7:0]        b;
		logic [7:0]        a;
		logic              check;
		logic [7:0]        er;
		logic [7:0]        eg;
		logic [7:0]        eb;
	} row_t;

	row_t              rows [$];
	logic              clk;
	logic              reset;
	logic              pixel_strobe;
	logic [ADDR_W-1:0] pixel_number;
	logic [7:0]        src_r;
	logic [7:0]        src_g;
	logic [7:0]        src_b;
	logic [7:0]        src_a;
	logic              frame_start;
	logic              blend_done;
	logic              blend_busy;
	logic [ADDR_W-1:0] blend_pixel;
	logic [7:0]        blend_r;
	logic [7:0]        blend_g;
	logic [7:0]        blend_b;
	logic              scan_valid;
	logic [ADDR_W-1:0] scan_pixel;
	logic [7:0]        scan_r;
	logic [7:0]        scan_g;
	logic [7:0]        scan_b;
	logic              frame_done;
	logic              table_check;
	logic [7:0]        table_r;
	logic [7:0]        table_g;
	logic [7:0]        table_b;
	int                chk_errors;
	int                blends_checked;
	int                pixels_checked;
	int                tb_errors;
	logic              timed_out;
	int                frame_count;
	int                frame_target;

	compositor_top #(.ADDR_W(ADDR_W), .PIXELS(PIXELS)) dut0
	(
		.clk(clk), .reset(reset), .pixel_strobe(pixel_strobe), .pixel_number(pixel_number),
		.src_r(src_r), .src_g(src_g), .src_b(src_b), .src_a(src_a),
		.frame_start(frame_start), .blend_done(blend_done), .blend_busy(blend_busy),
		.blend_pixel(blend_pixel), .blend_r(blend_r), .blend_g(blend_g), .blend_b(blend_b),
		.scan_valid(scan_valid), .scan_pixel(scan_pixel), .scan_r(scan_r),
		.scan_g(scan_g), .scan_b(scan_b), .frame_done(frame_done)
	);

	compositor_checker #(.ADDR_W(ADDR_W), .PIXELS(PIXELS)) check0
	(
		.clk(clk), .reset(reset), .pixel_strobe(pixel_strobe), .pixel_number(pixel_number),
		.src_r(src_r), .src_g(src_g), .src_b(src_b), .src_a(src_a),
		.frame_start(frame_start), .blend_done(blend_done), .blend_busy(blend_busy),
		.blend_pixel(blend_pixel), .blend_r(blend_r), .blend_g(blend_g), .blend_b(blend_b),
		.scan_valid(scan_valid), .scan_pixel(scan_pixel), .scan_r(scan_r),
		.scan_g(scan_g), .scan_b(scan_b), .frame_done(frame_done),
		.table_check(table_check), .table_r(table_r), .table_g(table_g), .table_b(table_b),
		.error_count(chk_errors), .blend_count(blends_checked), .pixel_count(pixels_checked)
	);

	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// Count of finished frames so a scan that ends early is not missed
	always @(posedge clk)
	begin
		if (reset)
			frame_count <= 0;
		else if (frame_done)
			frame_count <= frame_count + 1;
	end

	// Fill pattern where every address bit shows in each channel
	function automatic logic [7:0] fill_r(input int p);
		return 8'(p * 15 + 15);
	endfunction

	function automatic logic [7:0] fill_g(input int p);
		return 8'(p * 37 + 11);
	endfunction

	function automatic logic [7:0] fill_b(input int p);
		return 8'(p ^ 165);
	endfunction

	task automatic add_row
	(
		input row_kind_t k,
		input int        p,
		input int        r,
		input int        g,
		input int        b,
		input int        a,
		input logic      chk,
		input int        er,
		input int        eg,
		input int        eb
	);
		row_t row;
		row.kind  = k;
		row.pix   = ADDR_W'(p);
		row.r     = 8'(r);
		row.g     = 8'(g);
		row.b     = 8'(b);
		row.a     = 8'(a);
		row.check = chk;
		row.er    = 8'(er);
		row.eg    = 8'(eg);
		row.eb    = 8'(eb);
		rows.push_back(row);
	endtask

	task automatic add_random_blends(input int n);
		int a;
		for (int i = 0; i < n; i++)
		begin
			// First two rows hit the alpha edges
			a = (i == 0) ? 0 : (i == 1) ? 255 : int'($urandom_range(254, 1));
			add_row(ROW_BLEND, int'($urandom_range(PIXELS - 1, 0)), int'($urandom_range(255, 0)),
				int'($urandom_range(255, 0)), int'($urandom_range(255, 0)), a, 1'b0, 0, 0, 0);
		end
	endtask

	task automatic build_table();
		for (int p = 0; p < PIXELS; p++)
			add_row(ROW_BLEND, p, fill_r(p), fill_g(p), fill_b(p), 255, 1'b1,
				fill_r(p), fill_g(p), fill_b(p));
		add_row(ROW_SCAN, 0, 0, 0, 0, 0, 1'b0, 0, 0, 0);
		// Alpha 0 keeps the destination
		add_row(ROW_BLEND, 2, 200, 100, 50, 0, 1'b1, fill_r(2), fill_g(2), fill_b(2));
		add_row(ROW_BLEND, 5, 1, 2, 3, 255, 1'b1, 1, 2, 3);
		add_row(ROW_BLEND, 5, 128, 64, 192, 17, 1'b1, 9, 6, 15);
		add_row(ROW_SCAN, 0, 0, 0, 0, 0, 1'b0, 0, 0, 0);
		add_random_blends(12);
		// Blends racing a running scan
		add_row(ROW_SCAN_START, 0, 0, 0, 0, 0, 1'b0, 0, 0, 0);
		add_random_blends(6);
		add_row(ROW_SCAN_WAIT, 0, 0, 0, 0, 0, 1'b0, 0, 0, 0);
		add_row(ROW_SCAN, 0, 0, 0, 0, 0, 1'b0, 0, 0, 0);
	endtask

	task automatic wait_for_idle();
		int n;
		n = 0;
		while (blend_busy && n < TIMEOUT)
		begin
			@(negedge clk);
			n++;
		end
		if (blend_busy)
		begin
			$display("Timed out after %0d cycles waiting for blend_busy to fall", TIMEOUT);
			tb_errors++;
			timed_out = 1'b1;
		end
	endtask

	task automatic wait_for_frame();
		int n;
		n = 0;
		while (frame_count < frame_target && n < TIMEOUT)
		begin
			@(negedge clk);
			n++;
		end
		if (frame_count < frame_target)
		begin
			$display("Timed out after %0d cycles waiting for frame_done", TIMEOUT);
			tb_errors++;
			timed_out = 1'b1;
		end
		// Reader passes through its done state before the next frame_start
		repeat (2) @(negedge clk);
	endtask

	task automatic start_frame();
		frame_target = frame_count + 1;
		frame_start  = 1'b1;
		@(negedge clk);
		frame_start  = 1'b0;
	endtask

	task automatic apply_row(input row_t row);
		case (row.kind)
			ROW_BLEND:
			begin
				wait_for_idle();
				if (!timed_out)
				begin
					pixel_number = row.pix;
					src_r        = row.r;
					src_g        = row.g;
					src_b        = row.b;
					src_a        = row.a;
					table_check  = row.check;
					table_r      = row.er;
					table_g      = row.eg;
					table_b      = row.eb;
					pixel_strobe = 1'b1;
					@(negedge clk);
					pixel_strobe = 1'b0;
				end
			end
			ROW_SCAN:
			begin
				// Quiet scan with no blend in flight
				wait_for_idle();
				start_frame();
				wait_for_frame();
			end
			ROW_SCAN_START:
				start_frame();
			default:
				wait_for_frame();
		endcase
	endtask

	initial
	begin
		void'($urandom(58));
		reset        = 1'b1;
		pixel_strobe = 1'b0;
		pixel_number = '0;
		src_r        = '0;
		src_g        = '0;
		src_b        = '0;
		src_a        = '0;
		frame_start  = 1'b0;
		table_check  = 1'b0;
		table_r      = '0;
		table_g      = '0;
		table_b      = '0;
		tb_errors    = 0;
		timed_out    = 1'b0;
		frame_target = 0;
		build_table();
		repeat (8) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		// Idle stretch with outputs held low
		repeat (6) @(negedge clk);
		for (int i = 0; i < rows.size() && !timed_out; i++)
			apply_row(rows[i]);
		if (!timed_out)
			wait_for_idle();
		repeat (4) @(negedge clk);
		$display("Errors: %0d (checker %0d, timeouts %0d), blends checked %0d, pixels checked %0d",
			chk_errors + tb_errors, chk_errors, tb_errors, blends_checked, pixels_checked);
		if (chk_errors + tb_errors == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

//--- verilog.f
design/compositor_pkg.sv
design/fb_bus_if.sv
design/alpha_blender.sv
design/scanout_reader.sv
design/fb_arbiter.sv
design/frame_buffer.sv
design/compositor_top.sv
verification/compositor_checker.sv
verification/tb_compositor.sv

//--- run_sim.sh
#!/bin/sh
# Builds the compositor testbench with Verilator and runs it
# Exit status is 1 when the log holds the fail message
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing -Wno-fatal -f verilog.f --top-module tb_compositor \
	-o sim_compositor > build.log 2>&1 || { cat build.log; echo "Simulation failed" > sim.log; }
[ -x obj_dir/sim_compositor ] && { ./obj_dir/sim_compositor > sim.log 2>&1 || echo "Simulation failed" >> sim.log; }
cat sim.log
grep -q "Simulation failed" sim.log && exit 1 || exit 0
